// ==== logic/id_isa_pkg.sv ====
// RV32I instruction-set definitions for the decode stage
// Word widths, major opcodes and the function codes checked by the decoder
`default_nettype none

package id_isa_pkg;

  // Data, address and instruction words
  typedef logic [31:0] xlen_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_addr_t;

  // Supported major opcodes, everything else is illegal
  typedef enum logic [6:0] {
    OPCODE_OP     = 7'h33,
    OPCODE_OP_IMM = 7'h13,
    OPCODE_LUI    = 7'h37,
    OPCODE_AUIPC  = 7'h17,
    OPCODE_LOAD   = 7'h03,
    OPCODE_STORE  = 7'h23,
    OPCODE_BRANCH = 7'h63,
    OPCODE_JAL    = 7'h6f
  } opcode_e;

  // ALU funct3
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // Branch funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // Load/store funct3, stores use only the signed codes
  localparam logic [2:0] F3_MEM_B  = 3'b000;
  localparam logic [2:0] F3_MEM_H  = 3'b001;
  localparam logic [2:0] F3_MEM_W  = 3'b010;
  localparam logic [2:0] F3_MEM_BU = 3'b100;
  localparam logic [2:0] F3_MEM_HU = 3'b101;

  // funct7, ALT selects SUB and SRA
  localparam logic [6:0] F7_BASE = 7'b000_0000;
  localparam logic [6:0] F7_ALT  = 7'b010_0000;

  // Address step for the second half of a misaligned access
  localparam xlen_t INSTR_BYTES = 32'd4;

endpackage

`default_nettype wire

// ==== logic/id_ctrl_pkg.sv ====
// Decode-control definitions shared by decoder, operand mux and sequencer
// ALU operations, operand selects, access size and sequencer states
`default_nettype none

package id_ctrl_pkg;

  // ALU operations, compares are used by branches
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_XOR  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_AND  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  // Operand A source
  typedef enum logic [1:0] {
    OP_A_REG_A  = 2'd0,
    OP_A_FWD    = 2'd1,
    OP_A_CURRPC = 2'd2,
    OP_A_ZERO   = 2'd3
  } op_a_sel_e;

  // Operand B source
  typedef enum logic {
    OP_B_REG_B = 1'b0,
    OP_B_IMM   = 1'b1
  } op_b_sel_e;

  // Immediate feeding operand B
  typedef enum logic [2:0] {
    IMM_B_I         = 3'd0,
    IMM_B_S         = 3'd1,
    IMM_B_B         = 3'd2,
    IMM_B_U         = 3'd3,
    IMM_B_J         = 3'd4,
    IMM_B_INCR_ADDR = 3'd5
  } imm_b_sel_e;

  // Memory access size
  typedef logic [1:0] lsu_type_t;
  localparam lsu_type_t LSU_WORD = 2'd0;
  localparam lsu_type_t LSU_HALF = 2'd1;
  localparam lsu_type_t LSU_BYTE = 2'd2;

  // ID/EX sequencer states
  typedef enum logic {
    FIRST_CYCLE = 1'b0,
    MULTI_CYCLE = 1'b1
  } id_fsm_e;

endpackage

`default_nettype wire

// ==== logic/id_decoder.sv ====
// RV32I instruction decoder
// Turns an instruction word into register addresses, enables, operand
// selects, LSU controls and instruction-class flags
`timescale 1ns/1ps
`default_nettype none

module id_decoder
  import id_isa_pkg::*, id_ctrl_pkg::*;
#(
  parameter bit RV32E = 1'b0
) (
  input  instr_t     instr_i,
  output reg_addr_t  rf_raddr_a_o,
  output reg_addr_t  rf_raddr_b_o,
  output reg_addr_t  rf_waddr_o,
  output logic       rf_ren_a_o,
  output logic       rf_ren_b_o,
  output logic       rf_we_o,
  output alu_op_e    alu_operator_o,
  output op_a_sel_e  op_a_sel_o,
  output op_b_sel_e  op_b_sel_o,
  output imm_b_sel_e imm_b_sel_o,
  output logic       lsu_req_o,
  output logic       lsu_we_o,
  output logic       lsu_sign_ext_o,
  output lsu_type_t  lsu_type_o,
  output logic       branch_o,
  output logic       jump_o,
  output logic       illegal_o
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  // Shared ALU op lookup for OP and OP-IMM, alt picks SUB/SRA
  function automatic alu_op_e alu_op_from_f3(logic [2:0] f3, logic alt);
    alu_op_e op;
    case (f3)
      F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:     op = ALU_SLL;
      F3_SLT:     op = ALU_SLT;
      F3_SLTU:    op = ALU_SLTU;
      F3_XOR:     op = ALU_XOR;
      F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      op = ALU_OR;
      default:    op = ALU_AND;
    endcase
    return op;
  endfunction

  // Instruction fields
  assign opcode       = opcode_e'(instr_i[6:0]);
  assign funct3       = instr_i[14:12];
  assign funct7       = instr_i[31:25];
  assign rf_raddr_a_o = instr_i[19:15];
  assign rf_raddr_b_o = instr_i[24:20];
  assign rf_waddr_o   = instr_i[11:7];

  //////////////////////////////
  // Opcode decode
  //////////////////////////////

  always_comb begin
    // Defaults, nothing enabled
    rf_ren_a_o     = 1'b0;
    rf_ren_b_o     = 1'b0;
    rf_we_o        = 1'b0;
    alu_operator_o = ALU_ADD;
    op_a_sel_o     = OP_A_REG_A;
    op_b_sel_o     = OP_B_IMM;
    imm_b_sel_o    = IMM_B_I;
    lsu_req_o      = 1'b0;
    lsu_we_o       = 1'b0;
    lsu_sign_ext_o = 1'b0;
    lsu_type_o     = LSU_WORD;
    branch_o       = 1'b0;
    jump_o         = 1'b0;
    illegal_o      = 1'b0;

    case (opcode)
      OPCODE_OP: begin
        rf_ren_a_o     = 1'b1;
        rf_ren_b_o     = 1'b1;
        rf_we_o        = 1'b1;
        op_b_sel_o     = OP_B_REG_B;
        alu_operator_o = alu_op_from_f3(funct3, funct7 == F7_ALT);
        // ALT only valid for SUB and SRA
        if (funct7 == F7_ALT) begin
          illegal_o = !(funct3 inside {F3_ADD_SUB, F3_SRL_SRA});
        end else if (funct7 != F7_BASE) begin
          illegal_o = 1'b1;
        end
      end
      OPCODE_OP_IMM: begin
        rf_ren_a_o     = 1'b1;
        rf_we_o        = 1'b1;
        alu_operator_o = alu_op_from_f3(funct3,
                                        (funct3 == F3_SRL_SRA) && (funct7 == F7_ALT));
        // Shift amounts live in imm[4:0], upper bits are funct7
        if (funct3 == F3_SLL) begin
          illegal_o = (funct7 != F7_BASE);
        end else if (funct3 == F3_SRL_SRA) begin
          illegal_o = !(funct7 inside {F7_BASE, F7_ALT});
        end
      end
      OPCODE_LUI: begin
        rf_we_o     = 1'b1;
        op_a_sel_o  = OP_A_ZERO;
        imm_b_sel_o = IMM_B_U;
      end
      OPCODE_AUIPC: begin
        rf_we_o     = 1'b1;
        op_a_sel_o  = OP_A_CURRPC;
        imm_b_sel_o = IMM_B_U;
      end
      OPCODE_LOAD: begin
        // Address is rs1 + I immediate
        rf_ren_a_o     = 1'b1;
        rf_we_o        = 1'b1;
        lsu_req_o      = 1'b1;
        lsu_sign_ext_o = ~funct3[2];
        case (funct3)
          F3_MEM_B, F3_MEM_BU: lsu_type_o = LSU_BYTE;
          F3_MEM_H, F3_MEM_HU: lsu_type_o = LSU_HALF;
          F3_MEM_W:            lsu_type_o = LSU_WORD;
          default:             illegal_o  = 1'b1;
        endcase
      end
      OPCODE_STORE: begin
        rf_ren_a_o  = 1'b1;
        rf_ren_b_o  = 1'b1;
        lsu_req_o   = 1'b1;
        lsu_we_o    = 1'b1;
        imm_b_sel_o = IMM_B_S;
        case (funct3)
          F3_MEM_B: lsu_type_o = LSU_BYTE;
          F3_MEM_H: lsu_type_o = LSU_HALF;
          F3_MEM_W: lsu_type_o = LSU_WORD;
          default:  illegal_o  = 1'b1;
        endcase
      end
      OPCODE_BRANCH: begin
        // ALU does the compare, target comes from the B immediate
        rf_ren_a_o  = 1'b1;
        rf_ren_b_o  = 1'b1;
        branch_o    = 1'b1;
        op_b_sel_o  = OP_B_REG_B;
        imm_b_sel_o = IMM_B_B;
        case (funct3)
          F3_BEQ:  alu_operator_o = ALU_EQ;
          F3_BNE:  alu_operator_o = ALU_NE;
          F3_BLT:  alu_operator_o = ALU_LT;
          F3_BGE:  alu_operator_o = ALU_GE;
          F3_BLTU: alu_operator_o = ALU_LTU;
          F3_BGEU: alu_operator_o = ALU_GEU;
          default: illegal_o      = 1'b1;
        endcase
      end
      OPCODE_JAL: begin
        // Target is PC + J immediate
        rf_we_o     = 1'b1;
        jump_o      = 1'b1;
        op_a_sel_o  = OP_A_CURRPC;
        imm_b_sel_o = IMM_B_J;
      end
      default: illegal_o = 1'b1;
    endcase

    // RV32E has only x0..x15
    if (RV32E && ((rf_ren_a_o && rf_raddr_a_o[4]) || (rf_ren_b_o && rf_raddr_b_o[4]) ||
                  (rf_we_o && rf_waddr_o[4]))) begin
      illegal_o = 1'b1;
    end

    // Illegal instructions must not touch state
    if (illegal_o) begin
      rf_ren_a_o = 1'b0;
      rf_ren_b_o = 1'b0;
      rf_we_o    = 1'b0;
      lsu_req_o  = 1'b0;
      lsu_we_o   = 1'b0;
      branch_o   = 1'b0;
      jump_o     = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== logic/id_operand_mux.sv ====
// ALU operand multiplexers
// Builds the sign-extended immediates and selects operands A and B
`timescale 1ns/1ps
`default_nettype none

module id_operand_mux
  import id_isa_pkg::*, id_ctrl_pkg::*;
(
  input  instr_t     instr_i,
  input  xlen_t      pc_i,
  input  xlen_t      rf_rdata_a_i,
  input  xlen_t      rf_rdata_b_i,
  input  xlen_t      lsu_addr_last_i,
  input  op_a_sel_e  op_a_sel_i,
  input  op_b_sel_e  op_b_sel_i,
  input  imm_b_sel_e imm_b_sel_i,
  output xlen_t      alu_operand_a_o,
  output xlen_t      alu_operand_b_o
);

  xlen_t imm_i_type;
  xlen_t imm_s_type;
  xlen_t imm_b_type;
  xlen_t imm_u_type;
  xlen_t imm_j_type;
  xlen_t imm_b;

  // Immediate formats, sign bit always instr[31]
  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                       instr_i[11:8], 1'b0};
  assign imm_u_type = {instr_i[31:12], 12'b0};
  assign imm_j_type = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  // Immediate for operand B
  always_comb begin
    case (imm_b_sel_i)
      IMM_B_I: imm_b = imm_i_type;
      IMM_B_S: imm_b = imm_s_type;
      IMM_B_B: imm_b = imm_b_type;
      IMM_B_U: imm_b = imm_u_type;
      IMM_B_J: imm_b = imm_j_type;
      default: imm_b = INSTR_BYTES;
    endcase
  end

  // Operand A
  always_comb begin
    unique case (op_a_sel_i)
      OP_A_REG_A:  alu_operand_a_o = rf_rdata_a_i;
      OP_A_FWD:    alu_operand_a_o = lsu_addr_last_i;
      OP_A_CURRPC: alu_operand_a_o = pc_i;
      OP_A_ZERO:   alu_operand_a_o = '0;
    endcase
  end

  // Operand B
  assign alu_operand_b_o = (op_b_sel_i == OP_B_IMM) ? imm_b : rf_rdata_b_i;

endmodule

`default_nettype wire

// ==== logic/id_ex_sequencer.sv ====
// ID/EX sequencer
// First/multi-cycle FSM with memory, branch and jump stalls, instruction
// completion and a single pc-set pulse per control transfer
`timescale 1ns/1ps
`default_nettype none

module id_ex_sequencer
  import id_ctrl_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic instr_valid_i,
  input  logic lsu_req_dec_i,
  input  logic branch_dec_i,
  input  logic jump_dec_i,
  input  logic branch_decision_i,
  input  logic ex_valid_i,
  input  logic lsu_resp_valid_i,
  output logic first_cycle_o,
  output logic stall_o,
  output logic instr_done_o,
  output logic pc_set_o,
  output logic branch_taken_o
);

  id_fsm_e id_fsm_q, id_fsm_d;
  logic    branch_set_q, branch_set_d;
  logic    jump_set_raw;
  logic    set_done_q, set_done_d;
  logic    stall_mem, stall_branch, stall_jump;
  logic    multicycle_done;

  assign first_cycle_o = instr_valid_i & (id_fsm_q == FIRST_CYCLE);

  // Loads and stores wait on the LSU, control transfers on EX
  assign multicycle_done = lsu_req_dec_i ? lsu_resp_valid_i : ex_valid_i;

  // Memory ops always stall the first cycle, then until the response
  assign stall_mem = instr_valid_i & lsu_req_dec_i & (~lsu_resp_valid_i | first_cycle_o);

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb begin
    id_fsm_d     = id_fsm_q;
    stall_branch = 1'b0;
    stall_jump   = 1'b0;
    branch_set_d = 1'b0;
    jump_set_raw = 1'b0;

    if (instr_valid_i) begin
      unique case (id_fsm_q)
        FIRST_CYCLE: begin
          if (lsu_req_dec_i) begin
            id_fsm_d = MULTI_CYCLE;
          end else if (branch_dec_i) begin
            // Taken branch sets the PC next cycle from the flopped decision
            id_fsm_d     = branch_decision_i ? MULTI_CYCLE : FIRST_CYCLE;
            stall_branch = branch_decision_i;
            branch_set_d = branch_decision_i;
          end else if (jump_dec_i) begin
            id_fsm_d     = MULTI_CYCLE;
            stall_jump   = 1'b1;
            jump_set_raw = 1'b1;
          end
        end
        MULTI_CYCLE: begin
          if (multicycle_done) begin
            id_fsm_d = FIRST_CYCLE;
          end else begin
            stall_branch = branch_dec_i;
            stall_jump   = jump_dec_i;
          end
        end
      endcase
    end
  end

  assign stall_o      = stall_mem | stall_branch | stall_jump;
  assign instr_done_o = instr_valid_i & ~stall_o;

  // Guard is set by the first pc-set and cleared once the instruction finishes
  assign set_done_d     = (branch_set_q | jump_set_raw | set_done_q) & ~instr_done_o;
  assign pc_set_o       = (branch_set_q | jump_set_raw) & ~set_done_q;
  assign branch_taken_o = branch_set_q & ~set_done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_fsm_q     <= FIRST_CYCLE;
      branch_set_q <= 1'b0;
      set_done_q   <= 1'b0;
    end else begin
      // State holds while no instruction is present
      if (instr_valid_i) begin
        id_fsm_q <= id_fsm_d;
      end
      branch_set_q <= branch_set_d;
      set_done_q   <= set_done_d;
    end
  end

endmodule

`default_nettype wire

// ==== logic/id_stage.sv ====
// Instruction decode and dispatch stage
// Connects decoder, operand mux and sequencer, applies the second-address
// override for misaligned accesses and gates the enables
`timescale 1ns/1ps
`default_nettype none

module id_stage
  import id_isa_pkg::*, id_ctrl_pkg::*;
#(
  parameter bit RV32E = 1'b0
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      instr_valid_i,
  input  logic      branch_decision_i,
  input  logic      ex_valid_i,
  input  logic      lsu_resp_valid_i,
  input  logic      lsu_addr_incr_req_i,
  input  instr_t    instr_rdata_i,
  input  xlen_t     pc_id_i,
  input  xlen_t     rf_rdata_a_i,
  input  xlen_t     rf_rdata_b_i,
  input  xlen_t     lsu_addr_last_i,
  output reg_addr_t rf_raddr_a_o,
  output reg_addr_t rf_raddr_b_o,
  output reg_addr_t rf_waddr_o,
  output logic      rf_ren_a_o,
  output logic      rf_ren_b_o,
  output logic      rf_we_o,
  output logic      illegal_insn_o,
  output logic      lsu_req_o,
  output logic      lsu_we_o,
  output logic      lsu_sign_ext_o,
  output logic      pc_set_o,
  output logic      instr_done_o,
  output lsu_type_t lsu_type_o,
  output xlen_t     lsu_wdata_o,
  output alu_op_e   alu_operator_o,
  output xlen_t     alu_operand_a_o,
  output xlen_t     alu_operand_b_o
);

  op_a_sel_e  op_a_sel_dec, op_a_sel;
  op_b_sel_e  op_b_sel_dec, op_b_sel;
  imm_b_sel_e imm_b_sel_dec, imm_b_sel;
  logic       rf_ren_a_dec, rf_ren_b_dec, rf_we_dec;
  logic       lsu_req_dec, branch_dec, jump_dec, illegal_dec;
  logic       first_cycle;

  id_decoder #(
    .RV32E(RV32E)
  ) u_decoder (
    .instr_i       (instr_rdata_i),
    .rf_raddr_a_o  (rf_raddr_a_o),
    .rf_raddr_b_o  (rf_raddr_b_o),
    .rf_waddr_o    (rf_waddr_o),
    .rf_ren_a_o    (rf_ren_a_dec),
    .rf_ren_b_o    (rf_ren_b_dec),
    .rf_we_o       (rf_we_dec),
    .alu_operator_o(alu_operator_o),
    .op_a_sel_o    (op_a_sel_dec),
    .op_b_sel_o    (op_b_sel_dec),
    .imm_b_sel_o   (imm_b_sel_dec),
    .lsu_req_o     (lsu_req_dec),
    .lsu_we_o      (lsu_we_o),
    .lsu_sign_ext_o(lsu_sign_ext_o),
    .lsu_type_o    (lsu_type_o),
    .branch_o      (branch_dec),
    .jump_o        (jump_dec),
    .illegal_o     (illegal_dec)
  );

  // Second half of a misaligned access: last address + 4
  assign op_a_sel  = lsu_addr_incr_req_i ? OP_A_FWD        : op_a_sel_dec;
  assign op_b_sel  = lsu_addr_incr_req_i ? OP_B_IMM        : op_b_sel_dec;
  assign imm_b_sel = lsu_addr_incr_req_i ? IMM_B_INCR_ADDR : imm_b_sel_dec;

  id_operand_mux u_operand_mux (
    .instr_i        (instr_rdata_i),
    .pc_i           (pc_id_i),
    .rf_rdata_a_i   (rf_rdata_a_i),
    .rf_rdata_b_i   (rf_rdata_b_i),
    .lsu_addr_last_i(lsu_addr_last_i),
    .op_a_sel_i     (op_a_sel),
    .op_b_sel_i     (op_b_sel),
    .imm_b_sel_i    (imm_b_sel),
    .alu_operand_a_o(alu_operand_a_o),
    .alu_operand_b_o(alu_operand_b_o)
  );

  id_ex_sequencer u_seq (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .instr_valid_i    (instr_valid_i),
    .lsu_req_dec_i    (lsu_req_dec),
    .branch_dec_i     (branch_dec),
    .jump_dec_i       (jump_dec),
    .branch_decision_i(branch_decision_i),
    .ex_valid_i       (ex_valid_i),
    .lsu_resp_valid_i (lsu_resp_valid_i),
    .first_cycle_o    (first_cycle),
    .stall_o          (),
    .instr_done_o     (instr_done_o),
    .pc_set_o         (pc_set_o),
    .branch_taken_o   ()
  );

  // Enables only for valid, legal instructions
  assign illegal_insn_o = instr_valid_i & illegal_dec;
  assign rf_ren_a_o     = instr_valid_i & ~illegal_dec & rf_ren_a_dec;
  assign rf_ren_b_o     = instr_valid_i & ~illegal_dec & rf_ren_b_dec;
  assign rf_we_o        = instr_valid_i & rf_we_dec;

  // One request per load/store, issued in its first cycle
  assign lsu_req_o   = lsu_req_dec & first_cycle;
  assign lsu_wdata_o = rf_rdata_b_i;

endmodule

`default_nettype wire

// ==== verification/id_stage_checker.sv ====
// Sequencer assertions for the decode stage
// Watches pc-set pulses, LSU requests and the FSM state after reset
`timescale 1ns/1ps
`default_nettype none

module id_stage_checker
  import id_ctrl_pkg::*;
(
  input logic    clk_i,
  input logic    rst_ni,
  input logic    pc_set_i,
  input logic    lsu_req_i,
  input logic    illegal_insn_i,
  input id_fsm_e fsm_state_i
);

  // One pulse per control transfer, never two back to back
  pc_set_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_set_i |=> !pc_set_i)
    else $error("pc_set_o high in two consecutive cycles");

  // Illegal instructions never reach the LSU
  no_req_when_illegal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(lsu_req_i && illegal_insn_i))
    else $error("lsu_req_o raised for an illegal instruction");

  // FSM leaves reset in its first-cycle state
  first_cycle_after_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> (fsm_state_i == FIRST_CYCLE))
    else $error("sequencer not in FIRST_CYCLE after reset");

endmodule

bind id_stage id_stage_checker u_checker (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .pc_set_i      (pc_set_o),
  .lsu_req_i     (lsu_req_o),
  .illegal_insn_i(illegal_insn_o),
  .fsm_state_i   (u_seq.id_fsm_q)
);

`default_nettype wire

// ==== verification/id_stage_tb.sv ====
// Testbench for the instruction decode and dispatch stage
// Replays instruction vectors from a stimulus file, checks operands,
// enables, LSU request, pc-set pulses and completion timing
`timescale 1ns/1ps
`default_nettype none

module id_stage_tb
  import id_isa_pkg::*, id_ctrl_pkg::*;
();

  localparam int     CLK_PERIOD    = 8;
  localparam int     RESET_CYCLES  = 10;
  localparam int     NUM_FIELDS    = 14;
  localparam int     MAX_VECTORS   = 32;
  localparam int     DONE_TIMEOUT  = 20;
  localparam instr_t END_MARKER    = 32'hffff_ffff;
  localparam xlen_t  LSU_ADDR_LAST = 32'h0000_2ffe;
  localparam string  STIM_FILE     = "verification/id_stimulus.txt";

  logic      clk;
  logic      rst_n;
  logic      instr_valid;
  logic      branch_decision;
  logic      ex_valid;
  logic      lsu_resp_valid;
  logic      lsu_addr_incr;
  instr_t    instr_rdata;
  xlen_t     pc_id;
  xlen_t     rf_rdata_a;
  xlen_t     rf_rdata_b;
  xlen_t     lsu_addr_last;
  reg_addr_t rf_raddr_a;
  reg_addr_t rf_raddr_b;
  reg_addr_t rf_waddr;
  logic      rf_ren_a;
  logic      rf_ren_b;
  logic      rf_we;
  logic      illegal_insn;
  logic      lsu_req;
  logic      lsu_we;
  logic      lsu_sign_ext;
  logic      pc_set;
  logic      instr_done;
  lsu_type_t lsu_type;
  xlen_t     lsu_wdata;
  alu_op_e   alu_operator;
  xlen_t     alu_operand_a;
  xlen_t     alu_operand_b;

  // Vector fields, NUM_FIELDS words per instruction
  logic [31:0] stim_mem [0:NUM_FIELDS*MAX_VECTORS-1];
  int          errors;
  int          vectors;
  logic        aborted;

  id_stage #(
    .RV32E(1'b0)
  ) dut0 (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .instr_valid_i      (instr_valid),
    .branch_decision_i  (branch_decision),
    .ex_valid_i         (ex_valid),
    .lsu_resp_valid_i   (lsu_resp_valid),
    .lsu_addr_incr_req_i(lsu_addr_incr),
    .instr_rdata_i      (instr_rdata),
    .pc_id_i            (pc_id),
    .rf_rdata_a_i       (rf_rdata_a),
    .rf_rdata_b_i       (rf_rdata_b),
    .lsu_addr_last_i    (lsu_addr_last),
    .rf_raddr_a_o       (rf_raddr_a),
    .rf_raddr_b_o       (rf_raddr_b),
    .rf_waddr_o         (rf_waddr),
    .rf_ren_a_o         (rf_ren_a),
    .rf_ren_b_o         (rf_ren_b),
    .rf_we_o            (rf_we),
    .illegal_insn_o     (illegal_insn),
    .lsu_req_o          (lsu_req),
    .lsu_we_o           (lsu_we),
    .lsu_sign_ext_o     (lsu_sign_ext),
    .pc_set_o           (pc_set),
    .instr_done_o       (instr_done),
    .lsu_type_o         (lsu_type),
    .lsu_wdata_o        (lsu_wdata),
    .alu_operator_o     (alu_operator),
    .alu_operand_a_o    (alu_operand_a),
    .alu_operand_b_o    (alu_operand_b)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic report_mismatch(input int idx, input string what,
                                 input logic [31:0] got, input logic [31:0] expected);
    errors++;
    $display("CHECK FAILED at %0t: vector %0d %s = %h, expected %h",
             $time, idx, what, got, expected);
  endtask

  // Store flag and read enables {lsu_we, ren_b, ren_a} by opcode
  function automatic logic [2:0] expected_enables(input instr_t instr);
    logic [2:0] en;
    case (instr[6:0])
      OPCODE_OP, OPCODE_BRANCH:   en = 3'b011;
      OPCODE_STORE:               en = 3'b111;
      OPCODE_OP_IMM, OPCODE_LOAD: en = 3'b001;
      default:                    en = 3'b000;
    endcase
    return en;
  endfunction

  // Access size from the low funct3 bits
  function automatic lsu_type_t expected_lsu_type(input instr_t instr);
    lsu_type_t size;
    case (instr[13:12])
      2'b00:   size = LSU_BYTE;
      2'b01:   size = LSU_HALF;
      default: size = LSU_WORD;
    endcase
    return size;
  endfunction

  //////////////////////////////
  // One instruction
  //////////////////////////////

  task automatic run_vector(input int idx);
    int          base;
    int          resp_delay;
    int          cycle;
    int          pc_sets;
    int          exp_cycles;
    logic        done_seen;
    instr_t      instr;
    logic [31:0] exp_op_a;
    logic [31:0] exp_op_b;
    logic [31:0] exp_alu;
    logic        exp_we;
    logic        exp_req;
    logic [31:0] exp_pc_sets;
    logic        exp_ill;
    logic [2:0]  exp_en;
    logic        exp_sext;
    base        = idx * NUM_FIELDS;
    instr       = stim_mem[base];
    resp_delay  = int'(stim_mem[base+5]);
    exp_op_a    = stim_mem[base+7];
    exp_op_b    = stim_mem[base+8];
    exp_alu     = stim_mem[base+9];
    exp_we      = stim_mem[base+10][0];
    exp_req     = stim_mem[base+11][0];
    exp_pc_sets = stim_mem[base+12];
    exp_ill     = stim_mem[base+13][0];
    exp_en      = exp_ill ? 3'b000 : expected_enables(instr);
    // LBU and LHU zero-extend, other loads sign-extend
    exp_sext    = !(instr[14:12] inside {3'b100, 3'b101});
    // Memory ops end on the response, control transfers one cycle later
    if (exp_req) begin
      exp_cycles = resp_delay;
    end else if (exp_pc_sets != 0) begin
      exp_cycles = 1;
    end else begin
      exp_cycles = 0;
    end

    @(posedge clk);
    #1;
    instr_rdata     = instr;
    pc_id           = stim_mem[base+1];
    rf_rdata_a      = stim_mem[base+2];
    rf_rdata_b      = stim_mem[base+3];
    branch_decision = stim_mem[base+4][0];
    lsu_addr_incr   = stim_mem[base+6][0];
    instr_valid     = 1'b1;

    cycle     = 0;
    pc_sets   = 0;
    done_seen = 1'b0;
    while (!done_seen && cycle < DONE_TIMEOUT) begin
      lsu_resp_valid = (resp_delay != 0) && (cycle == resp_delay);
      @(negedge clk);
      if (pc_set) pc_sets++;
      if (cycle == 0) begin
        // Operands only mean something for legal instructions
        if (!exp_ill && alu_operand_a !== exp_op_a)
          report_mismatch(idx, "operand A", alu_operand_a, exp_op_a);
        if (!exp_ill && alu_operand_b !== exp_op_b)
          report_mismatch(idx, "operand B", alu_operand_b, exp_op_b);
        if (!exp_ill && 32'(alu_operator) !== exp_alu)
          report_mismatch(idx, "ALU op", 32'(alu_operator), exp_alu);
        if (rf_we !== exp_we)
          report_mismatch(idx, "rf_we_o", 32'(rf_we), 32'(exp_we));
        if (lsu_req !== exp_req)
          report_mismatch(idx, "lsu_req_o", 32'(lsu_req), 32'(exp_req));
        if (illegal_insn !== exp_ill)
          report_mismatch(idx, "illegal_insn_o", 32'(illegal_insn), 32'(exp_ill));
        if (exp_req && lsu_wdata !== rf_rdata_b)
          report_mismatch(idx, "store data", lsu_wdata, rf_rdata_b);
        // Register file ports
        if (rf_ren_a !== exp_en[0])
          report_mismatch(idx, "rf_ren_a_o", 32'(rf_ren_a), 32'(exp_en[0]));
        if (rf_ren_b !== exp_en[1])
          report_mismatch(idx, "rf_ren_b_o", 32'(rf_ren_b), 32'(exp_en[1]));
        if (exp_en[0] && rf_raddr_a !== instr[19:15])
          report_mismatch(idx, "rs1 address", 32'(rf_raddr_a), 32'(instr[19:15]));
        if (exp_en[1] && rf_raddr_b !== instr[24:20])
          report_mismatch(idx, "rs2 address", 32'(rf_raddr_b), 32'(instr[24:20]));
        if (exp_we && rf_waddr !== instr[11:7])
          report_mismatch(idx, "rd address", 32'(rf_waddr), 32'(instr[11:7]));
        // LSU controls
        if (lsu_we !== exp_en[2])
          report_mismatch(idx, "lsu_we_o", 32'(lsu_we), 32'(exp_en[2]));
        if (exp_req && lsu_type !== expected_lsu_type(instr))
          report_mismatch(idx, "lsu_type_o", 32'(lsu_type), 32'(expected_lsu_type(instr)));
        if (exp_req && !exp_en[2] && lsu_sign_ext !== exp_sext)
          report_mismatch(idx, "lsu_sign_ext_o", 32'(lsu_sign_ext), 32'(exp_sext));
      end else if (lsu_req !== 1'b0) begin
        report_mismatch(idx, "lsu_req_o after first cycle", 32'(lsu_req), 32'd0);
      end
      if (instr_done) done_seen = 1'b1;
      @(posedge clk);
      #1;
      if (!done_seen) cycle++;
    end

    // Idle cycle before the next instruction
    instr_valid     = 1'b0;
    lsu_resp_valid  = 1'b0;
    lsu_addr_incr   = 1'b0;
    branch_decision = 1'b0;

    if (!done_seen) begin
      errors++;
      aborted = 1'b1;
      $display("Timeout: instr_done_o never rose for vector %0d within %0d cycles",
               idx, DONE_TIMEOUT);
    end else begin
      if (pc_sets != int'(exp_pc_sets))
        report_mismatch(idx, "pc_set_o pulses", 32'(pc_sets), exp_pc_sets);
      if (cycle != exp_cycles)
        report_mismatch(idx, "cycles to done", 32'(cycle), 32'(exp_cycles));
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    int idx;
    rst_n           = 1'b0;
    instr_valid     = 1'b0;
    branch_decision = 1'b0;
    ex_valid        = 1'b1;
    lsu_resp_valid  = 1'b0;
    lsu_addr_incr   = 1'b0;
    instr_rdata     = 32'h0000_0013;
    pc_id           = '0;
    rf_rdata_a      = '0;
    rf_rdata_b      = '0;
    lsu_addr_last   = LSU_ADDR_LAST;
    errors          = 0;
    vectors         = 0;
    aborted         = 1'b0;
    $readmemh(STIM_FILE, stim_mem);

    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Outputs idle out of reset
    @(negedge clk);
    if (pc_set || lsu_req || rf_we || instr_done) begin
      errors++;
      $display("CHECK FAILED at %0t: outputs not idle after reset", $time);
    end

    idx = 0;
    while (!aborted && idx < MAX_VECTORS && stim_mem[idx*NUM_FIELDS] !== END_MARKER) begin
      run_vector(idx);
      vectors++;
      idx++;
    end
    if (vectors == 0) begin
      errors++;
      $display("No stimulus vectors were read from %s", STIM_FILE);
    end

    $display("Vectors run: %0d, errors: %0d", vectors, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
logic/id_isa_pkg.sv
logic/id_ctrl_pkg.sv
logic/id_decoder.sv
logic/id_operand_mux.sv
logic/id_ex_sequencer.sv
logic/id_stage.sv
verification/id_stage_checker.sv
verification/id_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the decode-stage testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module id_stage_tb -f sources.f \
  || { echo "Build failed"; exit 1; }

./obj_dir/Vid_stage_tb > sim.log 2>&1
status=$?
cat sim.log

[ "$status" -eq 0 ] && ! grep -q "ERRORS FOUND" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== verification/id_stimulus.txt ====
// instr pc rdata_a rdata_b branch_taken resp_delay addr_incr
// exp_op_a exp_op_b exp_alu_op exp_rf_we exp_lsu_req exp_pc_sets exp_illegal
002081b3 00000100 00000011 00000022 0 0 0 00000011 00000022 0 1 0 0 0
407302b3 00000104 00001000 00000ff0 0 0 0 00001000 00000ff0 1 1 0 0 0
40915233 00000108 80000000 00000004 0 0 0 80000000 00000004 7 1 0 0 0
ffb10093 0000010c 00000064 deadbeef 0 0 0 00000064 fffffffb 0 1 0 0 0
7ff44413 00000110 0000f0f0 00000000 0 0 0 0000f0f0 000007ff 2 1 0 0 0
00319113 00000114 00000001 00000000 0 0 0 00000001 00000003 5 1 0 0 0
12345537 00000118 aaaaaaaa 55555555 0 0 0 00000000 12345000 0 1 0 0 0
fffff597 00000400 aaaaaaaa 55555555 0 0 0 00000400 fffff000 0 1 0 0 0
00812603 00000404 00001000 00000000 0 1 0 00001000 00000008 0 1 1 0 0
fff20683 00000408 00002000 00000000 0 3 0 00002000 ffffffff 0 1 1 0 0
00532623 0000040c 00003000 cafef00d 0 2 0 00003000 0000000c 0 0 1 0 0
fe709e23 00000410 00004000 12345678 0 4 0 00004000 fffffffc 0 0 1 0 0
00812603 00000414 00001000 00000000 0 2 1 00002ffe 00000004 0 1 1 0 0
00532623 00000418 00003000 0badc0de 0 1 1 00002ffe 00000004 0 0 1 0 0
00208863 0000041c 00000055 00000055 1 0 0 00000055 00000055 a 0 0 1 0
fe419ce3 00000420 00000007 00000009 0 0 0 00000007 00000009 b 0 0 0 0
0062e463 00000424 00000001 00000002 1 0 0 00000001 00000002 e 0 0 1 0
001000ef 00000200 00000000 00000000 0 0 0 00000200 00000800 0 1 0 1 0
ffdff06f 00000300 00000000 00000000 0 0 0 00000300 fffffffc 0 1 0 1 0
0000000b 00000500 00000000 00000000 0 0 0 00000000 00000000 0 0 0 0 1
022081b3 00000504 00000000 00000000 0 0 0 00000000 00000000 0 0 0 0 1
00813603 00000508 00000000 00000000 0 0 0 00000000 00000000 0 0 0 0 1
402091b3 0000050c 00000000 00000000 0 0 0 00000000 00000000 0 0 0 0 1
ffffffff 00000000 00000000 00000000 0 0 0 00000000 00000000 0 0 0 0 0
